/* Makefile */
VERILATOR ?= verilator
TOP       ?= dataCacheTb
FILELIST  ?= filelist.f
OBJDIR    ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: compile
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	@if grep -q "STATUS: FAIL" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "STATUS: PASS" $(LOG); then echo "Simulation ended early"; exit 1; fi
	@echo "Simulation passed"

clean:
	rm -rf $(OBJDIR) $(LOG)

/* design/cacheController.sv */
module cacheController #(
    parameter int blockSize = 4,
    localparam int offW = $clog2(blockSize)
) (
    input  logic            clk,
    input  logic            arstN,
    input  logic            access,
    input  logic            write,
    input  logic            hit,
    input  logic            victimDirty,
    input  logic            iStall,
    input  logic            busReady,
    output logic [offW-1:0] beat,
    output logic            busRequest,
    output logic            busWrite,
    output logic            fillWrite,
    output logic            lineFill,
    output logic            cpuWrite,
    output logic            stall
);
    import cachePkg::*;

    // --------------------------------------------------
    // State and counter
    // --------------------------------------------------

    ctrlStateT state;
    ctrlStateT stateNext;

    // Word offset of the beat on the bus
    logic [offW-1:0] beatQ;

    // Current beat is the final word of the block
    logic lastBeat;

    // Access present that the cache cannot serve
    logic miss;

    assign miss = access && !hit;
    assign lastBeat = (beatQ == offW'(blockSize - 1));

    // --------------------------------------------------
    // Next state
    // --------------------------------------------------

    always_comb begin
        stateNext = state;
        case (state)
            ctrlIdle: begin
                // Instruction fetch owns the bus, wait here
                if (miss && !iStall) begin
                    if (victimDirty) begin
                        stateNext = ctrlWriteBack;
                    end else begin
                        stateNext = ctrlFill;
                    end
                end
            end
            ctrlWriteBack: begin
                // Whole victim block out, then fetch
                if (busReady && lastBeat) begin
                    stateNext = ctrlFill;
                end
            end
            ctrlFill: begin
                // Back to idle where the access now hits
                if (busReady && lastBeat) begin
                    stateNext = ctrlIdle;
                end
            end
            default: begin
                stateNext = ctrlIdle;
            end
        endcase
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state <= ctrlIdle;
        end else begin
            state <= stateNext;
        end
    end

    // --------------------------------------------------
    // Beat counter
    // --------------------------------------------------

    // Steps once per busReady pulse
    // Wraps to zero between write-back and fill
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            beatQ <= '0;
        end else if (state == ctrlIdle) begin
            beatQ <= '0;
        end else if (busReady) begin
            beatQ <= beatQ + 1'b1;
        end
    end

    assign beat = beatQ;

    // --------------------------------------------------
    // Bus and cache strobes
    // --------------------------------------------------

    always_comb begin
        busRequest = 1'b0;
        busWrite = 1'b0;
        fillWrite = 1'b0;
        lineFill = 1'b0;
        case (state)
            ctrlWriteBack: begin
                busRequest = 1'b1;
                busWrite = 1'b1;
            end
            ctrlFill: begin
                busRequest = 1'b1;
                // Capture the word in its ready cycle
                fillWrite = busReady;
                // Last word also validates the line
                lineFill = busReady && lastBeat;
            end
            default: begin
                busRequest = 1'b0;
            end
        endcase
    end

    // Store only once the block is resident
    assign cpuWrite = (state == ctrlIdle) && access && write && hit;

    // Miss stalls in its own request cycle
    // Held through every bus beat
    assign stall = (state != ctrlIdle) || miss;

endmodule

/* design/cacheMemory.sv */
module cacheMemory #(
    parameter int blockSize = 4,
    parameter int lines = 2,
    localparam int offW = $clog2(blockSize),
    localparam int setW = $clog2(lines),
    localparam int tagW = 30 - offW - setW
) (
    input  logic              clk,
    input  logic              arstN,
    input  logic [setW-1:0]   setIdx,
    input  logic [tagW-1:0]   tag,
    input  logic [offW-1:0]   wordIdx,
    input  cachePkg::wordT    dataIn,
    input  cachePkg::byteMaskT byteMask,
    input  logic              cpuWrite,
    input  logic              fillWrite,
    input  logic              lineFill,
    output logic              hit,
    output logic              victimDirty,
    output logic [tagW-1:0]   victimTag,
    output cachePkg::wordT    hitWord,
    output cachePkg::wordT    victimWord
);
    import cachePkg::*;

    // --------------------------------------------------
    // Storage
    // --------------------------------------------------

    // Data words, indexed by way, set and word offset
    wordT dataMem [2][lines][blockSize];

    // Tag per line in each way
    logic [tagW-1:0] tagMem [2][lines];

    // Line state bits, way in the outer dimension
    logic [1:0][lines-1:0] validQ;
    logic [1:0][lines-1:0] dirtyQ;

    // Least recently used way per set
    logic [lines-1:0] lruQ;

    // Per-way tag match
    logic [1:0] wayHit;

    // Way holding the hit, way 0 when nothing matches
    logic hitWay;

    // Way picked for replacement
    logic victimWay;

    // --------------------------------------------------
    // Lookup
    // --------------------------------------------------

    // Valid gates the compare so unwritten tags never match
    assign wayHit[0] = validQ[0][setIdx] && (tagMem[0][setIdx] == tag);
    assign wayHit[1] = validQ[1][setIdx] && (tagMem[1][setIdx] == tag);

    assign hit = |wayHit;
    assign hitWay = wayHit[1];

    // First invalid way wins, way 0 first
    // Both valid falls back to the LRU way
    always_comb begin
        if (!validQ[0][setIdx]) begin
            victimWay = 1'b0;
        end else if (!validQ[1][setIdx]) begin
            victimWay = 1'b1;
        end else begin
            victimWay = lruQ[setIdx];
        end
    end

    // Only a valid line can need write-back
    assign victimDirty = validQ[victimWay][setIdx] && dirtyQ[victimWay][setIdx];
    assign victimTag = tagMem[victimWay][setIdx];

    // Word reads for the pipeline and for write-back
    assign hitWord = dataMem[hitWay][setIdx][wordIdx];
    assign victimWord = dataMem[victimWay][setIdx][wordIdx];

    // --------------------------------------------------
    // Data and tag writes
    // --------------------------------------------------

    // Fill beats land whole in the victim way
    // Pipeline writes merge bytes into the hit way
    always_ff @(posedge clk) begin
        if (fillWrite) begin
            dataMem[victimWay][setIdx][wordIdx] <= dataIn;
        end else if (cpuWrite) begin
            for (int b = 0; b < 4; b++) begin
                if (byteMask[b]) begin
                    dataMem[hitWay][setIdx][wordIdx][8*b +: 8] <= dataIn[8*b +: 8];
                end
            end
        end
    end

    // New tag takes effect with the last fill word
    always_ff @(posedge clk) begin
        if (lineFill) begin
            tagMem[victimWay][setIdx] <= tag;
        end
    end

    // --------------------------------------------------
    // Line state
    // --------------------------------------------------

    // LRU moves on write hits and on completed fills
    // It always ends up naming the way not just used
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            validQ <= '0;
            dirtyQ <= '0;
            lruQ <= '0;
        end else if (lineFill) begin
            // Freshly fetched block matches memory
            validQ[victimWay][setIdx] <= 1'b1;
            dirtyQ[victimWay][setIdx] <= 1'b0;
            lruQ[setIdx] <= ~victimWay;
        end else if (cpuWrite) begin
            dirtyQ[hitWay][setIdx] <= 1'b1;
            lruQ[setIdx] <= ~hitWay;
        end
    end

endmodule

/* design/cachePkg.sv */
package cachePkg;

    // --------------------------------------------------
    // Basic widths
    // --------------------------------------------------

    // One data word on the pipeline or the bus
    typedef logic [31:0] wordT;

    // Byte address, low two bits unused for word accesses
    typedef logic [31:0] addrT;

    // Byte enables, bit n covers byte n of the word
    typedef logic [3:0] byteMaskT;

    // --------------------------------------------------
    // Request bundles
    // --------------------------------------------------

    // Access from the memory stage
    typedef struct packed {
        logic     read;
        logic     write;
        addrT     addr;
        wordT     wdata;
        byteMaskT byteMask;
    } cpuReqT;

    // Single-word bus drive from the cache
    typedef struct packed {
        logic request;
        logic write;
        addrT addr;
        wordT wdata;
    } busReqT;

    // Miss handling states
    typedef enum logic [1:0] {
        ctrlIdle,
        ctrlWriteBack,
        ctrlFill
    } ctrlStateT;

endpackage

/* design/dataCache.sv */
module dataCache #(
    parameter int blockSize = 4,
    parameter int lines = 2
) (
    input  logic             clk,
    input  logic             arstN,
    input  cachePkg::cpuReqT cpuReq,
    input  logic             iStall,
    output cachePkg::wordT   rd,
    output logic             stall,
    output cachePkg::busReqT busReq,
    input  cachePkg::wordT   hRData,
    input  logic             busReady
);
    import cachePkg::*;

    localparam int offW = $clog2(blockSize);
    localparam int setW = $clog2(lines);
    localparam int tagW = 30 - offW - setW;

    // --------------------------------------------------
    // Address split
    // --------------------------------------------------

    logic [tagW-1:0] tag;
    logic [setW-1:0] setIdx;
    logic [offW-1:0] wordIdx;
    logic [offW-1:0] beat;
    logic [tagW-1:0] victimTag;
    logic busRequest;
    logic busWrite;

    // Byte offset sits below the word offset
    assign tag = cpuReq.addr[31 -: tagW];
    assign setIdx = cpuReq.addr[offW + 2 +: setW];

    // Bus beats walk the block, otherwise the pipeline's word
    assign wordIdx = busRequest ? beat : cpuReq.addr[2 +: offW];

    // Fill address keeps the request tag
    // Write-back address uses the tag of the line leaving
    addrT fillAddr;
    addrT wbAddr;
    addrT busAddr;

    assign fillAddr = {tag, setIdx, beat, 2'b00};
    assign wbAddr = {victimTag, setIdx, beat, 2'b00};
    assign busAddr = busWrite ? wbAddr : fillAddr;

    // --------------------------------------------------
    // Data selections
    // --------------------------------------------------

    logic hit;
    logic victimDirty;
    logic cpuWrite;
    logic fillWrite;
    logic lineFill;
    wordT dataIn;
    wordT hitWord;
    wordT victimWord;

    // Bus data during a fill, store data otherwise
    assign dataIn = fillWrite ? hRData : cpuReq.wdata;

    // Reads always complete from the cache
    assign rd = hitWord;

    // Write-back data comes from the victim way
    assign busReq = '{request: busRequest, write: busWrite, addr: busAddr, wdata: victimWord};

    cacheMemory #(.blockSize(blockSize), .lines(lines)) mem0 (.clk, .arstN, .setIdx, .tag,
        .wordIdx, .dataIn, .byteMask(cpuReq.byteMask), .cpuWrite, .fillWrite, .lineFill,
        .hit, .victimDirty, .victimTag, .hitWord, .victimWord);

    cacheController #(.blockSize(blockSize)) ctrl0 (.clk, .arstN,
        .access(cpuReq.read || cpuReq.write), .write(cpuReq.write), .hit, .victimDirty,
        .iStall, .busReady, .beat, .busRequest, .busWrite, .fillWrite, .lineFill,
        .cpuWrite, .stall);

endmodule

/* filelist.f */
design/cachePkg.sv
design/cacheMemory.sv
design/cacheController.sv
design/dataCache.sv
test/busMemory.sv
test/dataCacheTb.sv

/* test/busMemory.sv */
module busMemory #(
    parameter int maxDelay = 4,
    parameter int seedInit = 32'h7482
) (
    input  logic             clk,
    input  logic             arstN,
    input  cachePkg::busReqT busReq,
    output cachePkg::wordT   hRData,
    output logic             busReady
);
    import cachePkg::*;

    // Sparse backing store keyed by word address
    wordT mem [addrT];

    // Every finished beat, wdata holds the word moved either way
    busReqT beatLog [$];

    integer seed = seedInit;
    int waitCnt;
    logic busy;
    addrT wordAddr;

    assign wordAddr = {busReq.addr[31:2], 2'b00};

    // Unwritten words read back as their own address
    function automatic wordT readWord(input addrT a);
        if (mem.exists(a)) begin
            return mem[a];
        end
        return a;
    endfunction

    always @(posedge clk or negedge arstN) begin
        busReqT entry;
        if (!arstN) begin
            busReady <= 1'b0;
            hRData <= '0;
            busy <= 1'b0;
            waitCnt <= 0;
        end else begin
            busReady <= 1'b0;
            if (busReady) begin
                // Pulse cycle, next beat starts one cycle later
                busy <= 1'b0;
            end else if (busReq.request && !busy) begin
                busy <= 1'b1;
                waitCnt <= 1 + int'($unsigned($random(seed)) % maxDelay);
            end else if (busy) begin
                if (waitCnt <= 1) begin
                    busReady <= 1'b1;
                    entry = busReq;
                    if (busReq.write) begin
                        mem[wordAddr] = busReq.wdata;
                    end else begin
                        hRData <= readWord(wordAddr);
                        entry.wdata = readWord(wordAddr);
                    end
                    beatLog.push_back(entry);
                end else begin
                    waitCnt <= waitCnt - 1;
                end
            end
        end
    end

endmodule

/* test/dataCacheTb.sv */
module dataCacheTb;
    import cachePkg::*;

    localparam int blockSize = 4;
    localparam int lines = 2;
    localparam int maxDelay = 4;
    localparam int numAccesses = 150;
    localparam int period = 40;
    localparam int resetCycles = 5;
    // Request cycle, longest wait and the ready cycle
    localparam int longestBeat = maxDelay + 2;
    localparam longint timeLimit =
        longint'(numAccesses) * blockSize * 2 * longestBeat * period + (resetCycles + 10) * period;

    logic clk;
    logic arstN;
    cpuReqT cpuReq;
    logic iStall;
    wordT rd;
    logic stall;
    busReqT busReq;
    wordT hRData;
    logic busReady;

    integer seed = 32'h7482;
    int errorCount;
    int checkCount;

    // --------------------------------------------------
    // Reference model
    // --------------------------------------------------

    // Flat memory holds the newest value of every word
    wordT flatMem [addrT];
    // Shadow line state, block base address stands in for the tag
    addrT shadowBase [2][lines];
    bit shadowValid [2][lines];
    bit shadowDirty [2][lines];
    bit shadowLru [lines];

    dataCache #(.blockSize(blockSize), .lines(lines)) dut0 (.clk, .arstN, .cpuReq, .iStall,
        .rd, .stall, .busReq, .hRData, .busReady);

    busMemory #(.maxDelay(maxDelay), .seedInit(32'h7482)) busMem0 (.clk, .arstN, .busReq,
        .hRData, .busReady);

    initial begin
        clk = 1'b0;
        forever #(period / 2) clk = ~clk;
    end

    initial begin
        #(timeLimit);
        $display("Run timed out at %0t before all accesses finished", $time);
        $display("STATUS: FAIL");
        $finish;
    end

    task automatic checkWord(input string what, input wordT got, input wordT exp);
        checkCount++;
        if (got !== exp) begin
            errorCount++;
            $display("Mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic checkAddr(input string what, input addrT got, input addrT exp);
        checkCount++;
        if (got !== exp) begin
            errorCount++;
            $display("Mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic checkFlag(input string what, input logic got, input logic exp);
        checkCount++;
        if (got !== exp) begin
            errorCount++;
            $display("Mismatch at %0t: %s got %b expected %b", $time, what, got, exp);
        end
    endtask

    // Same rule as the bus side, unwritten words equal their address
    function automatic wordT modelRead(input addrT a);
        if (flatMem.exists(a)) begin
            return flatMem[a];
        end
        return a;
    endfunction

    function automatic wordT mergeBytes(input wordT old, input wordT data, input byteMaskT mask);
        wordT result;
        result = old;
        for (int b = 0; b < 4; b++) begin
            if (mask[b]) begin
                result[8*b +: 8] = data[8*b +: 8];
            end
        end
        return result;
    endfunction

    // First invalid way, way 0 first, else the LRU way
    function automatic int pickVictim(input int s);
        if (!shadowValid[0][s]) begin
            return 0;
        end
        if (!shadowValid[1][s]) begin
            return 1;
        end
        return int'(shadowLru[s]);
    endfunction

    // --------------------------------------------------
    // Bus beat checks
    // --------------------------------------------------

    task automatic checkBeats(input int startIdx, input bit miss, input bit wb,
                              input addrT wbBase, input addrT fillBase);
        int wbCount;
        int expCount;
        int seen;
        addrT expAddr;
        busReqT entry;
        wbCount = wb ? blockSize : 0;
        expCount = miss ? wbCount + blockSize : 0;
        seen = busMem0.beatLog.size() - startIdx;
        if (seen != expCount) begin
            errorCount++;
            $display("Wrong number of bus beats at %0t: %0d seen, %0d expected",
                $time, seen, expCount);
        end
        for (int i = 0; i < expCount && i < seen; i++) begin
            entry = busMem0.beatLog[startIdx + i];
            if (i < wbCount) begin
                // Victim words leave in ascending order with the newest data
                expAddr = wbBase + addrT'(4 * i);
                checkFlag("write-back beat direction", entry.write, 1'b1);
                checkAddr("write-back address", entry.addr, expAddr);
                checkWord("write-back data", entry.wdata, modelRead(expAddr));
            end else begin
                expAddr = fillBase + addrT'(4 * (i - wbCount));
                checkFlag("fill beat direction", entry.write, 1'b0);
                checkAddr("fill address", entry.addr, expAddr);
            end
        end
    endtask

    // --------------------------------------------------
    // One random access
    // --------------------------------------------------

    task automatic runAccess(input int n);
        cpuReqT req;
        bit holdBus;
        int holdCycles;
        int s;
        int hitWay;
        int victim;
        bit expHit;
        bit expWb;
        addrT blockBase;
        addrT wbBase;
        int startIdx;
        int errorsBefore;
        errorsBefore = errorCount;
        req.write = $random(seed) & 1;
        req.read = !req.write;
        // Eight blocks over two sets, so sets conflict often
        req.addr = 32'h0000_1000 + (addrT'($random(seed)) & 32'h0000_007C);
        req.wdata = $random(seed);
        req.byteMask = byteMaskT'($random(seed));
        holdBus = (($random(seed) & 3) == 0);
        holdCycles = 1 + int'($unsigned($random(seed)) % 3);
        blockBase = req.addr & ~addrT'(blockSize * 4 - 1);
        s = int'((req.addr / (blockSize * 4)) % lines);
        hitWay = -1;
        for (int w = 0; w < 2; w++) begin
            if (shadowValid[w][s] && shadowBase[w][s] == blockBase) begin
                hitWay = w;
            end
        end
        expHit = (hitWay >= 0);
        victim = pickVictim(s);
        expWb = !expHit && shadowValid[victim][s] && shadowDirty[victim][s];
        wbBase = shadowBase[victim][s];
        startIdx = busMem0.beatLog.size();

        @(posedge clk);
        cpuReq <= req;
        iStall <= holdBus;
        @(negedge clk);
        checkFlag("stall in request cycle", stall, !expHit);
        if (expHit) begin
            checkFlag("bus request on hit", busReq.request, 1'b0);
        end
        if (holdBus) begin
            // Instruction side owns the bus, nothing may start
            // Each check follows an edge that saw iStall high
            for (int i = 0; i < holdCycles; i++) begin
                @(negedge clk);
                checkFlag("bus request under iStall", busReq.request, 1'b0);
                checkFlag("stall under iStall", stall, !expHit);
            end
            @(posedge clk);
            iStall <= 1'b0;
            @(negedge clk);
        end
        while (stall) begin
            @(negedge clk);
        end
        if (req.read) begin
            checkWord("read data", rd, modelRead(req.addr));
        end
        checkBeats(startIdx, !expHit, expWb, wbBase, blockBase);
        @(posedge clk);
        cpuReq <= '0;

        // Model update, LRU moves on fills and write hits only
        if (!expHit) begin
            shadowValid[victim][s] = 1'b1;
            shadowDirty[victim][s] = 1'b0;
            shadowBase[victim][s] = blockBase;
            shadowLru[s] = (victim == 0);
            hitWay = victim;
        end
        if (req.write) begin
            flatMem[req.addr] = mergeBytes(modelRead(req.addr), req.wdata, req.byteMask);
            shadowDirty[hitWay][s] = 1'b1;
            shadowLru[s] = (hitWay == 0);
        end
        $display("Access %0d %s %h %s%s: %s", n, req.write ? "write" : "read", req.addr,
            expHit ? "hit" : "miss", expWb ? " with write-back" : "",
            (errorCount == errorsBefore) ? "ok" : "error");
    endtask

    // --------------------------------------------------
    // Main sequence
    // --------------------------------------------------

    initial begin
        cpuReq = '0;
        iStall = 1'b0;
        arstN = 1'b0;
        errorCount = 0;
        checkCount = 0;
        for (int s = 0; s < lines; s++) begin
            shadowLru[s] = 1'b0;
            for (int w = 0; w < 2; w++) begin
                shadowValid[w][s] = 1'b0;
                shadowDirty[w][s] = 1'b0;
                shadowBase[w][s] = '0;
            end
        end
        repeat (resetCycles) @(posedge clk);
        arstN <= 1'b1;
        @(negedge clk);
        checkFlag("stall after reset", stall, 1'b0);
        checkFlag("bus request after reset", busReq.request, 1'b0);
        for (int n = 0; n < numAccesses; n++) begin
            runAccess(n);
        end
        $display("Accesses %0d, checks %0d, errors %0d", numAccesses, checkCount, errorCount);
        if (errorCount == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule
